// ==== common/snd_pkg.sv ====
package snd_pkg;

    // Sound CPU bus
    localparam int ADDR_W = 21;
    localparam int DATA_W = 8;

    // Program ROM window is the low 64 KB of the CPU space
    localparam int ROM_AW = 16;

    // Work RAM, 8 KB
    localparam int RAM_AW = 13;

    // Audio path
    localparam int SND_W     = 16;
    localparam int MIX_W     = SND_W + 3;
    localparam int SND_MAX   = 2 ** (SND_W - 1) - 1;
    localparam int SND_MIN   = -(2 ** (SND_W - 1));
    localparam int PERIOD_W  = 12;
    localparam int PHI_W     = PERIOD_W - DATA_W;
    localparam int AMP_SHIFT = 4;

    // Address regions seen by the decoder
    typedef enum logic [2:0] {
        REG_ROM,
        REG_RAM,
        REG_TONE,
        REG_LATCH,
        REG_NONE
    } region_e;

    // Tone register offsets, A[2:0]
    typedef enum logic [2:0] {
        CH0_PLO = 3'd0,
        CH0_PHI = 3'd1,
        CH0_VOL = 3'd2,
        CH1_PLO = 3'd3,
        CH1_PHI = 3'd4,
        CH1_VOL = 3'd5
    } tone_reg_e;

    // A[20] low is ROM, otherwise A[17:15] picks the peripheral
    function automatic region_e addr_region(input logic [ADDR_W-1:0] a);
        if (!a[20]) begin
            return REG_ROM;
        end
        case (a[17:15])
            3'b000:  return REG_RAM;
            3'b001:  return REG_TONE;
            3'b010:  return REG_LATCH;
            default: return REG_NONE;
        endcase
    endfunction

endpackage

// ==== bus/snd_bus_decode.sv ====
`timescale 1ns/1ps

module snd_bus_decode (
    input  logic                        clk,
    input  logic                        rst_n,

    // Sound CPU bus
    input  logic [snd_pkg::ADDR_W-1:0]  addr,
    input  logic                        wrn,
    input  logic                        rdn,
    input  logic                        sx,
    input  logic                        ce,

    // Read data sources
    input  logic [snd_pkg::DATA_W-1:0]  rom_data,
    input  logic                        rom_ok,
    input  logic [snd_pkg::DATA_W-1:0]  ram_dout,
    input  logic [snd_pkg::DATA_W-1:0]  tone_dout,
    input  logic [snd_pkg::DATA_W-1:0]  latch_dout,

    // Chip selects held from sx to ce
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        tone_cs,
    output logic                        latch_cs,
    output logic                        wr_stb,
    output logic [snd_pkg::DATA_W-1:0]  cpu_din,
    output logic                        wait_n
);

    snd_pkg::region_e           region;
    logic [snd_pkg::DATA_W-1:0] rd_mux;

    assign region = snd_pkg::addr_region(addr);

    // Writes land on the cycle-end strobe
    // The top qualifies the strobe with the chip select
    assign wr_stb = ce & ~wrn;

    // Selects are set on sx and dropped on ce
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            tone_cs  <= 1'b0;
            latch_cs <= 1'b0;
            wait_n   <= 1'b1;
        end else begin
            if (sx) begin
                rom_cs   <= region == snd_pkg::REG_ROM;
                ram_cs   <= region == snd_pkg::REG_RAM;
                tone_cs  <= region == snd_pkg::REG_TONE;
                latch_cs <= region == snd_pkg::REG_LATCH;
            end else if (ce) begin
                rom_cs   <= 1'b0;
                ram_cs   <= 1'b0;
                tone_cs  <= 1'b0;
                latch_cs <= 1'b0;
            end
            // Stall the CPU while the ROM request is outstanding
            wait_n <= !rom_cs || rom_ok;
        end
    end

    // Priority read mux where unmapped space floats high
    always_comb begin
        if (ram_cs) begin
            rd_mux = ram_dout;
        end else if (tone_cs) begin
            rd_mux = tone_dout;
        end else if (latch_cs) begin
            rd_mux = latch_dout;
        end else if (rom_cs) begin
            rd_mux = rom_data;
        end else begin
            rd_mux = 8'hff;
        end
    end

    // Only sampled during read cycles
    always_ff @(posedge clk) begin
        if (!rdn) begin
            cpu_din <= rd_mux;
        end
    end

    // A bus cycle never opens and closes on the same clock
    a_sx_ce_apart : assert property (@(posedge clk) disable iff (!rst_n)
        !(sx && ce))
        else $error("sx and ce high together");

    // CPU must hold the cycle open while waiting on ROM
    a_no_ce_in_wait : assert property (@(posedge clk) disable iff (!rst_n)
        ce |-> wait_n)
        else $error("ce raised while wait_n low");

endmodule

// ==== bus/snd_ram.sv ====
`timescale 1ns/1ps

module snd_ram (
    input  logic                        clk,
    input  logic [snd_pkg::RAM_AW-1:0]  addr,
    input  logic [snd_pkg::DATA_W-1:0]  din,
    input  logic                        we,
    output logic [snd_pkg::DATA_W-1:0]  dout
);

    // 8 KB work area for the sound program
    logic [snd_pkg::DATA_W-1:0] mem [2 ** snd_pkg::RAM_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        // Registered read, old data on a write cycle
        dout <= mem[addr];
    end

endmodule

// ==== src/snd_cmd_latch.sv ====
`timescale 1ns/1ps

module snd_cmd_latch (
    input  logic                        clk,
    input  logic                        rst_n,

    // From main CPU
    input  logic                        snreq,
    input  logic [snd_pkg::DATA_W-1:0]  latch,

    // Sound CPU read of the latch
    input  logic                        rd_ack,

    output logic [snd_pkg::DATA_W-1:0]  cmd,
    output logic                        irq_n
);

    logic pending;

    // Last command byte from the main CPU
    always_ff @(posedge clk) begin
        if (snreq) begin
            cmd <= latch;
        end
    end

    // New command beats an ack on the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (snreq) begin
            pending <= 1'b1;
        end else if (rd_ack) begin
            pending <= 1'b0;
        end
    end

    assign irq_n = ~pending;

endmodule

// ==== tone/snd_tone.sv ====
`timescale 1ns/1ps

module snd_tone (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cen_snd,

    // CPU register port
    input  snd_pkg::tone_reg_e                reg_addr,
    input  logic [snd_pkg::DATA_W-1:0]        din,
    input  logic                              we,
    output logic [snd_pkg::DATA_W-1:0]        dout,

    output logic signed [snd_pkg::SND_W-1:0]  ch0_amp,
    output logic signed [snd_pkg::SND_W-1:0]  ch1_amp,
    output logic                              tone_tick
);

    logic [snd_pkg::DATA_W-1:0]   plo [2];
    logic [snd_pkg::PHI_W-1:0]    phi [2];
    logic [snd_pkg::DATA_W-1:0]   vol [2];
    logic [snd_pkg::PERIOD_W-1:0] cnt [2];
    logic [1:0]                   phase;
    logic signed [snd_pkg::SND_W-1:0] amp [2];

    // Register file writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                plo[i] <= '0;
                phi[i] <= '0;
                vol[i] <= '0;
            end
        end else if (we) begin
            case (reg_addr)
                snd_pkg::CH0_PLO: plo[0] <= din;
                snd_pkg::CH0_PHI: phi[0] <= din[snd_pkg::PHI_W-1:0];
                snd_pkg::CH0_VOL: vol[0] <= din;
                snd_pkg::CH1_PLO: plo[1] <= din;
                snd_pkg::CH1_PHI: phi[1] <= din[snd_pkg::PHI_W-1:0];
                snd_pkg::CH1_VOL: vol[1] <= din;
                default: ;
            endcase
        end
    end

    // Readback, PHI upper nibble and offsets 6/7 read zero
    always_comb begin
        case (reg_addr)
            snd_pkg::CH0_PLO: dout = plo[0];
            snd_pkg::CH0_PHI: dout = {{(snd_pkg::DATA_W - snd_pkg::PHI_W){1'b0}}, phi[0]};
            snd_pkg::CH0_VOL: dout = vol[0];
            snd_pkg::CH1_PLO: dout = plo[1];
            snd_pkg::CH1_PHI: dout = {{(snd_pkg::DATA_W - snd_pkg::PHI_W){1'b0}}, phi[1]};
            snd_pkg::CH1_VOL: dout = vol[1];
            default:          dout = '0;
        endcase
    end

    for (genvar c = 0; c < 2; c++) begin : g_ch
        logic [snd_pkg::PERIOD_W-1:0] period;
        logic [snd_pkg::PERIOD_W-1:0] cnt_nxt;
        logic [snd_pkg::SND_W-1:0]    mag;

        assign period  = {phi[c], plo[c]};
        assign cnt_nxt = cnt[c] + 1'b1;

        // Half-period counter, phase toggles every period ticks
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt[c]   <= '0;
                phase[c] <= 1'b1;
            end else if (cen_snd) begin
                if (period == '0) begin
                    cnt[c] <= '0;
                end else if (cnt_nxt >= period) begin
                    cnt[c]   <= '0;
                    phase[c] <= ~phase[c];
                end else begin
                    cnt[c] <= cnt_nxt;
                end
            end
        end

        assign mag = {{(snd_pkg::SND_W - snd_pkg::DATA_W){1'b0}}, vol[c]} << snd_pkg::AMP_SHIFT;

        // Silent when the period is zero
        assign amp[c] = (period == '0) ? '0 :
                        phase[c]       ? $signed(mag) : -$signed(mag);
    end

    assign ch0_amp = amp[0];
    assign ch1_amp = amp[1];

    // Amplitudes are settled one cycle after the tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone_tick <= 1'b0;
        end else begin
            tone_tick <= cen_snd;
        end
    end

endmodule

// ==== tone/snd_mixer.sv ====
`timescale 1ns/1ps

module snd_mixer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              tick,
    input  logic signed [snd_pkg::SND_W-1:0]  ch0_amp,
    input  logic signed [snd_pkg::SND_W-1:0]  ch1_amp,
    input  logic                              enable_tone,
    input  logic [1:0]                        fxlevel,

    output logic signed [snd_pkg::SND_W-1:0]  snd,
    output logic                              sample,
    output logic                              peak
);

    // Headroom for two channels and a gain of 8
    logic signed [snd_pkg::MIX_W-1:0] a0;
    logic signed [snd_pkg::MIX_W-1:0] a1;
    logic signed [snd_pkg::MIX_W-1:0] sum;
    logic signed [snd_pkg::MIX_W-1:0] gained;
    logic                             clip_hi;
    logic                             clip_lo;

    assign a0 = ch0_amp;
    assign a1 = ch1_amp;

    // Channel enable mutes both voices
    assign sum = enable_tone ? a0 + a1 : '0;

    // Effects gain of 1, 2, 4 or 8
    assign gained = sum <<< fxlevel;

    assign clip_hi = gained > snd_pkg::SND_MAX;
    assign clip_lo = gained < snd_pkg::SND_MIN;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snd    <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            sample <= tick;
            if (tick) begin
                if (clip_hi) begin
                    snd <= snd_pkg::SND_W'(snd_pkg::SND_MAX);
                end else if (clip_lo) begin
                    snd <= snd_pkg::SND_W'(snd_pkg::SND_MIN);
                end else begin
                    snd <= gained[snd_pkg::SND_W-1:0];
                end
                // Flag follows each sample, not sticky
                peak <= clip_hi | clip_lo;
            end
        end
    end

endmodule

// ==== src/snd_top.sv ====
`timescale 1ns/1ps

module snd_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cen_snd,

    input  logic                              enable_tone,
    input  logic [1:0]                        fxlevel,

    // From main CPU
    input  logic                              snreq,
    input  logic [snd_pkg::DATA_W-1:0]        latch,

    // Sound CPU bus
    input  logic [snd_pkg::ADDR_W-1:0]        addr,
    input  logic                              wrn,
    input  logic                              rdn,
    input  logic                              sx,
    input  logic                              ce,
    input  logic [snd_pkg::DATA_W-1:0]        cpu_dout,
    output logic [snd_pkg::DATA_W-1:0]        cpu_din,
    output logic                              wait_n,
    output logic                              irq_n,

    // Program ROM
    output logic [snd_pkg::ROM_AW-1:0]        rom_addr,
    output logic                              rom_cs,
    input  logic [snd_pkg::DATA_W-1:0]        rom_data,
    input  logic                              rom_ok,

    output logic signed [snd_pkg::SND_W-1:0]  snd,
    output logic                              sample,
    output logic                              peak
);

    logic                             ram_cs;
    logic                             tone_cs;
    logic                             latch_cs;
    logic                             wr_stb;
    logic                             rd_ack;
    logic                             ram_we;
    logic                             tone_we;
    logic [snd_pkg::DATA_W-1:0]       ram_dout;
    logic [snd_pkg::DATA_W-1:0]       tone_dout;
    logic [snd_pkg::DATA_W-1:0]       cmd;
    logic signed [snd_pkg::SND_W-1:0] ch0_amp;
    logic signed [snd_pkg::SND_W-1:0] ch1_amp;
    logic                             tone_tick;

    assign rom_addr = addr[snd_pkg::ROM_AW-1:0];

    // Latch read completes on ce, which drops the interrupt
    assign rd_ack  = latch_cs & ce & ~rdn;
    assign ram_we  = ram_cs & wr_stb;
    assign tone_we = tone_cs & wr_stb;

    snd_cmd_latch u_latch (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .snreq    ( snreq    ),
        .latch    ( latch    ),
        .rd_ack   ( rd_ack   ),
        .cmd      ( cmd      ),
        .irq_n    ( irq_n    )
    );

    snd_bus_decode u_decode (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .addr       ( addr       ),
        .wrn        ( wrn        ),
        .rdn        ( rdn        ),
        .sx         ( sx         ),
        .ce         ( ce         ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .ram_dout   ( ram_dout   ),
        .tone_dout  ( tone_dout  ),
        .latch_dout ( cmd        ),
        .rom_cs     ( rom_cs     ),
        .ram_cs     ( ram_cs     ),
        .tone_cs    ( tone_cs    ),
        .latch_cs   ( latch_cs   ),
        .wr_stb     ( wr_stb     ),
        .cpu_din    ( cpu_din    ),
        .wait_n     ( wait_n     )
    );

    snd_ram u_ram (
        .clk   ( clk                          ),
        .addr  ( addr[snd_pkg::RAM_AW-1:0]    ),
        .din   ( cpu_dout                     ),
        .we    ( ram_we                       ),
        .dout  ( ram_dout                     )
    );

    snd_tone u_tone (
        .clk       ( clk                             ),
        .rst_n     ( rst_n                           ),
        .cen_snd   ( cen_snd                         ),
        .reg_addr  ( snd_pkg::tone_reg_e'(addr[2:0]) ),
        .din       ( cpu_dout                        ),
        .we        ( tone_we                         ),
        .dout      ( tone_dout                       ),
        .ch0_amp   ( ch0_amp                         ),
        .ch1_amp   ( ch1_amp                         ),
        .tone_tick ( tone_tick                       )
    );

    snd_mixer u_mixer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .tick        ( tone_tick   ),
        .ch0_amp     ( ch0_amp     ),
        .ch1_amp     ( ch1_amp     ),
        .enable_tone ( enable_tone ),
        .fxlevel     ( fxlevel     ),
        .snd         ( snd         ),
        .sample      ( sample      ),
        .peak        ( peak        )
    );

endmodule

// ==== dv/tb_snd.sv ====
`timescale 1ns/1ps

module tb_snd;

    localparam int WAIT_LIMIT = 64;
    localparam logic [snd_pkg::ADDR_W-1:0] RAM_BASE   = 21'h100000;
    localparam logic [snd_pkg::ADDR_W-1:0] TONE_BASE  = 21'h108000;
    localparam logic [snd_pkg::ADDR_W-1:0] LATCH_BASE = 21'h110000;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic                              cen_snd;
    logic                              enable_tone;
    logic [1:0]                        fxlevel;
    logic                              snreq;
    logic [snd_pkg::DATA_W-1:0]        latch;
    logic [snd_pkg::ADDR_W-1:0]        addr;
    logic                              wrn;
    logic                              rdn;
    logic                              sx;
    logic                              ce;
    logic [snd_pkg::DATA_W-1:0]        cpu_dout;
    logic [snd_pkg::DATA_W-1:0]        cpu_din;
    logic                              wait_n;
    logic                              irq_n;
    logic [snd_pkg::ROM_AW-1:0]        rom_addr;
    logic                              rom_cs;
    logic [snd_pkg::DATA_W-1:0]        rom_data;
    logic                              rom_ok;
    logic signed [snd_pkg::SND_W-1:0]  snd;
    logic                              sample;
    logic                              peak;

    integer     seed = 32'hc531;
    int         errors;
    int         checks;
    logic [1:0] cen_div;

    snd_top DUT (.*);

    always #4 clk = ~clk;

    // Audio clock enable, one tick every four cycles
    always @(negedge clk) begin
        cen_div <= cen_div + 2'd1;
        cen_snd <= (cen_div == 2'd3);
    end

    // ROM contents depend on every address bit
    function automatic logic [7:0] rom_byte(input logic [snd_pkg::ROM_AW-1:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
    endfunction

    task automatic check_byte(input string name, input logic [snd_pkg::DATA_W-1:0] got,
                              input logic [snd_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_region(input string name, input snd_pkg::region_e got,
                                input snd_pkg::region_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_sample(input string name, input logic signed [snd_pkg::SND_W-1:0] got,
                                input logic signed [snd_pkg::SND_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic do_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // One sound CPU cycle, the ROM answers after a random delay
    task automatic bus_cycle(input logic [snd_pkg::ADDR_W-1:0] a, input logic write,
                             input logic [snd_pkg::DATA_W-1:0] wdata,
                             input snd_pkg::region_e exp_region,
                             output logic [snd_pkg::DATA_W-1:0] rdata);
        snd_pkg::region_e got_region;
        int               rom_delay;
        int               exp_waits;
        int               waits;
        int               cyc;
        rom_delay = 0;
        if (exp_region == snd_pkg::REG_ROM) begin
            rom_delay = $unsigned($random(seed)) % 6;
        end
        exp_waits = rom_delay;
        waits     = 0;
        cyc       = 0;
        @(negedge clk);
        addr     = a;
        wrn      = !write;
        rdn      = write;
        cpu_dout = wdata;
        sx       = 1'b1;
        @(negedge clk);
        sx = 1'b0;
        // Selects were latched on the sx edge
        if (rom_cs) begin
            got_region = snd_pkg::REG_ROM;
        end else if (DUT.ram_cs) begin
            got_region = snd_pkg::REG_RAM;
        end else if (DUT.tone_cs) begin
            got_region = snd_pkg::REG_TONE;
        end else if (DUT.latch_cs) begin
            got_region = snd_pkg::REG_LATCH;
        end else begin
            got_region = snd_pkg::REG_NONE;
        end
        check_region("chip select", got_region, exp_region);
        // Data is valid from the second edge after sx once wait_n is high
        while (!(cyc > 0 && wait_n)) begin
            if (rom_cs && !rom_ok) begin
                if (rom_delay == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_byte(rom_addr);
                end else begin
                    rom_delay--;
                end
            end
            if (cyc > 0) begin
                waits++;
            end
            if (cyc == WAIT_LIMIT) begin
                timeout_fail("wait_n to rise");
            end
            @(negedge clk);
            cyc++;
        end
        rdata = cpu_din;
        if (exp_region == snd_pkg::REG_ROM) begin
            check_count("wait_n low cycles", waits, exp_waits);
        end
        ce = 1'b1;
        @(negedge clk);
        ce     = 1'b0;
        rdn    = 1'b1;
        wrn    = 1'b1;
        rom_ok = 1'b0;
    endtask

    task automatic bus_write(input logic [snd_pkg::ADDR_W-1:0] a,
                             input logic [snd_pkg::DATA_W-1:0] d, input snd_pkg::region_e r);
        logic [snd_pkg::DATA_W-1:0] unused;
        bus_cycle(a, 1'b1, d, r, unused);
    endtask

    task automatic bus_read(input logic [snd_pkg::ADDR_W-1:0] a, input snd_pkg::region_e r,
                            output logic [snd_pkg::DATA_W-1:0] d);
        bus_cycle(a, 1'b0, 8'h00, r, d);
    endtask

    task automatic main_cmd(input logic [snd_pkg::DATA_W-1:0] b);
        @(negedge clk);
        latch = b;
        snreq = 1'b1;
        @(negedge clk);
        snreq = 1'b0;
        check_bit("irq_n", irq_n, 1'b0);
    endtask

    task automatic wait_sample();
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!sample) begin
            if (cyc == WAIT_LIMIT) begin
                timeout_fail("a sample strobe");
            end
            @(negedge clk);
            cyc++;
        end
    endtask

    task automatic reset_values();
        check_bit("wait_n", wait_n, 1'b1);
        check_bit("irq_n", irq_n, 1'b1);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("sample", sample, 1'b0);
        check_bit("peak", peak, 1'b0);
        check_sample("snd", snd, 16'sd0);
    endtask

    task automatic rom_reads();
        logic [snd_pkg::ADDR_W-1:0] a;
        logic [snd_pkg::DATA_W-1:0] d;
        for (int i = 0; i < 12; i++) begin
            a = {1'b0, 20'($random(seed))};
            bus_read(a, snd_pkg::REG_ROM, d);
            check_byte("cpu_din rom", d, rom_byte(a[15:0]));
        end
    endtask

    task automatic ram_test();
        logic [snd_pkg::RAM_AW-1:0] offs [8];
        logic [snd_pkg::DATA_W-1:0] vals [8];
        logic [snd_pkg::DATA_W-1:0] d;
        // Top bits keep the random addresses apart
        for (int i = 0; i < 8; i++) begin
            offs[i] = {i[2:0], 10'($random(seed))};
            vals[i] = 8'($random(seed));
            bus_write(RAM_BASE | 21'(offs[i]), vals[i], snd_pkg::REG_RAM);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(RAM_BASE | 21'(offs[i]), snd_pkg::REG_RAM, d);
            check_byte("cpu_din ram", d, vals[i]);
        end
        // A[17:15] of 3 to 7 is unmapped
        for (int s = 3; s < 8; s++) begin
            bus_read(21'h100000 | (21'(s) << 15), snd_pkg::REG_NONE, d);
            check_byte("cpu_din unmapped", d, 8'hff);
        end
    endtask

    task automatic latch_test();
        logic [snd_pkg::DATA_W-1:0] d;
        main_cmd(8'ha7);
        bus_read(LATCH_BASE, snd_pkg::REG_LATCH, d);
        check_byte("cpu_din latch", d, 8'ha7);
        check_bit("irq_n", irq_n, 1'b1);
        main_cmd(8'h5e);
        bus_read(LATCH_BASE, snd_pkg::REG_LATCH, d);
        check_byte("cpu_din latch", d, 8'h5e);
        check_bit("irq_n", irq_n, 1'b1);
    endtask

    task automatic tone_regs();
        logic [snd_pkg::DATA_W-1:0] vals [8];
        logic [snd_pkg::DATA_W-1:0] d;
        logic [snd_pkg::DATA_W-1:0] exp;
        for (int i = 0; i < 8; i++) begin
            vals[i] = 8'($random(seed)) | 8'hf0;
            bus_write(TONE_BASE | 21'(i), vals[i], snd_pkg::REG_TONE);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(TONE_BASE | 21'(i), snd_pkg::REG_TONE, d);
            // PHI keeps 4 bits, offsets 6 and 7 have no register
            if (i == 1 || i == 4) begin
                exp = vals[i] & 8'h0f;
            end else if (i >= 6) begin
                exp = 8'h00;
            end else begin
                exp = vals[i];
            end
            check_byte("cpu_din tone", d, exp);
        end
    endtask

    task automatic tone_output(input logic [11:0] period, input logic [7:0] vol,
                               input logic [1:0] fx);
        logic signed [snd_pkg::SND_W-1:0] mag;
        logic                             neg;
        int                               n;
        do_reset();
        enable_tone = 1'b1;
        fxlevel     = fx;
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_VOL), vol, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_PHI), {4'h0, period[11:8]}, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_PLO), period[7:0], snd_pkg::REG_TONE);
        mag = 16'(vol) << (snd_pkg::AMP_SHIFT + fx);
        // Skip to the first clean edge of the square wave
        n = 0;
        wait_sample();
        while (snd == 0) begin
            if (n == 16) begin
                timeout_fail("the tone to start");
            end
            wait_sample();
            n++;
        end
        neg = snd[15];
        n   = 0;
        while (snd[15] == neg) begin
            if (n > 2 * period + 4) begin
                timeout_fail("the first sign change");
            end
            wait_sample();
            n++;
        end
        // Count samples over one half period
        neg = snd[15];
        n   = 0;
        check_sample("snd", snd, neg ? -mag : mag);
        while (n <= period + 2) begin
            wait_sample();
            n++;
            if (snd[15] != neg) begin
                break;
            end
            check_sample("snd", snd, neg ? -mag : mag);
        end
        check_count("samples per half period", n, period);
        // Muted output
        enable_tone = 1'b0;
        wait_sample();
        wait_sample();
        check_sample("snd muted", snd, 16'sd0);
        enable_tone = 1'b1;
    endtask

    task automatic saturation();
        do_reset();
        enable_tone = 1'b1;
        fxlevel     = 2'd3;
        // Both phases start high and stay there for 200 ticks
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_VOL), 8'd255, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH1_VOL), 8'd255, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH1_PLO), 8'd200, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_PLO), 8'd200, snd_pkg::REG_TONE);
        wait_sample();
        wait_sample();
        check_sample("snd clipped", snd, 16'sh7fff);
        check_bit("peak", peak, 1'b1);
        bus_write(TONE_BASE | 21'(snd_pkg::CH0_VOL), 8'd1, snd_pkg::REG_TONE);
        bus_write(TONE_BASE | 21'(snd_pkg::CH1_VOL), 8'd1, snd_pkg::REG_TONE);
        wait_sample();
        wait_sample();
        check_sample("snd small", snd, 16'sd2 * (16'sd1 << snd_pkg::AMP_SHIFT) * 16'sd8);
        check_bit("peak", peak, 1'b0);
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        cen_snd     = 1'b0;
        cen_div     = 2'd0;
        enable_tone = 1'b1;
        fxlevel     = 2'd0;
        snreq       = 1'b0;
        latch       = 8'h00;
        addr        = '0;
        wrn         = 1'b1;
        rdn         = 1'b1;
        sx          = 1'b0;
        ce          = 1'b0;
        cpu_dout    = 8'h00;
        rom_data    = 8'h00;
        rom_ok      = 1'b0;
        do_reset();
        reset_values();
        rom_reads();
        ram_test();
        latch_test();
        tone_regs();
        tone_output(12'd5, 8'd100, 2'd2);
        tone_output(12'h102, 8'd37, 2'd0);
        saturation();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/snd_pkg.sv
bus/snd_bus_decode.sv
bus/snd_ram.sv
src/snd_cmd_latch.sv
tone/snd_tone.sv
tone/snd_mixer.sv
src/snd_top.sv
dv/tb_snd.sv

// ==== Bender.yml ====
package:
  name: snd_board

sources:
  - common/snd_pkg.sv
  - bus/snd_bus_decode.sv
  - bus/snd_ram.sv
  - src/snd_cmd_latch.sv
  - tone/snd_tone.sv
  - tone/snd_mixer.sv
  - src/snd_top.sv
  - target: simulation
    files:
      - dv/tb_snd.sv
